//--- verilog.f
logic/icache_pkg.sv
logic/icache_tag_mem.sv
logic/icache_data_mem.sv
logic/icache_fill_ctrl.sv
logic/icache_bundle_align.sv
logic/icache_top.sv
test/icache_checker.sv
test/icache_tb.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, so the pipe status does not matter
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/icache_tb.sv
// ====================
// Instruction cache testbench
// Memory model, reference bundle, directed and random fetches
// ====================

`timescale 1ns/1ps

module icache_tb;

	localparam int WAIT_LIMIT = 200;

	logic                            rclk = 1'b0;
	logic                            arst_n;
	logic                            fetch_req;
	logic [31:0]                     pc;
	logic                            invalidate;
	logic                            busy;
	logic                            fetch_valid;
	logic [icache_pkg::BUNDLE_W-1:0] fetch_data;
	logic                            fetch_err;
	logic                            mem_req;
	logic [31:0]                     mem_addr;
	logic                            mem_ack;
	logic [icache_pkg::LINE_W-1:0]   mem_data;
	logic                            mem_err;

	// Scoreboard state
	logic [31:0] lfsr_state = 32'hbaa04eb1;
	logic [31:0] exp_pc_q [$];
	logic [31:0] exp_fill_q [$];
	logic [31:0] fill_log [$];
	bit          shadow_valid [128];
	logic [19:0] shadow_tag [128];
	int          req_count = 0;
	int          checks = 0;
	int          mismatches = 0;
	int          others = 0;

	icache_top #(.ADDR_W(32)) dut (
		.rclk(rclk), .arst_n(arst_n), .fetch_req(fetch_req), .pc(pc),
		.invalidate(invalidate), .busy(busy), .fetch_valid(fetch_valid),
		.fetch_data(fetch_data), .fetch_err(fetch_err), .mem_req(mem_req),
		.mem_addr(mem_addr), .mem_ack(mem_ack), .mem_data(mem_data), .mem_err(mem_err)
	);

	initial begin
		forever #10 rclk = ~rclk;
	end

	// ====================
	// Memory content rules
	// ====================

	// Byte at a is its low byte XOR the next byte up
	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		logic [31:0] s;
		s = a >> 8;
		return a[7:0] ^ s[7:0];
	endfunction

	// Bad lines sit where address bits 15:12 are all ones
	function automatic logic err_region(input logic [31:0] a);
		return a[15:12] == 4'hf;
	endfunction

	function automatic logic [icache_pkg::LINE_W-1:0] mem_line(input logic [31:0] la);
		logic [icache_pkg::LINE_W-1:0] d;
		d = '0;
		for (int i = 0; i < icache_pkg::LINE_BYTES; i++)
			d[i*8 +: 8] = mem_byte(la + 32'(i));
		return d;
	endfunction

	// Expected {fetch_err, fetch_data} for a fetch at a
	function automatic logic [icache_pkg::BUNDLE_W:0] expected_fetch(input logic [31:0] a);
		logic [icache_pkg::BUNDLE_W-1:0] b;
		for (int k = 0; k < icache_pkg::BUNDLE_BYTES; k++)
			b[k*8 +: 8] = mem_byte(a + 32'(k));
		return {err_region(a) | err_region(a + 32'd16), b};
	endfunction

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// ====================
	// Checking helpers
	// ====================

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("ERROR time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	task automatic abort_run(input string why);
		others++;
		$display("Timeout at %0t: %s", $time, why);
		$display("Checks %0d, mismatches %0d, other failures %0d", checks, mismatches, others);
		$display("TB FAILED");
		$finish;
	endtask

	// Direct-mapped shadow of the tags gives the expected fills, in order
	task automatic predict_fills(input logic [31:0] a);
		logic [31:0] ln [2];
		logic [6:0]  idx;
		ln[0] = {a[31:5], 5'd0};
		ln[1] = a + 32'd16;
		ln[1][4:0] = 5'd0;
		exp_fill_q.delete();
		for (int i = 0; i < 2; i++) begin
			idx = ln[i][11:5];
			if (!(i == 1 && ln[1] == ln[0]) &&
				!(shadow_valid[idx] && shadow_tag[idx] == ln[i][31:12])) begin
				exp_fill_q.push_back(ln[i]);
				shadow_valid[idx] = 1'b1;
				shadow_tag[idx] = ln[i][31:12];
			end
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < WAIT_LIMIT) begin
			@(negedge rclk);
			n++;
		end
		if (busy)
			abort_run("busy never dropped");
	endtask

	// One fetch, and with poke set a second request at b lands while busy
	task automatic fetch_once(input logic [31:0] a, input bit poke, input logic [31:0] b);
		int base_reqs;
		int cycles;
		bit seen;
		wait_idle();
		predict_fills(a);
		fill_log.delete();
		base_reqs = req_count;
		fetch_req = 1'b1;
		pc = a;
		exp_pc_q.push_back(a);
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge rclk);
			cycles++;
			fetch_req = poke && cycles == 1;
			if (poke && cycles == 1)
				pc = b;
			seen = fetch_valid;
			// Busy holds from the sampling edge through the valid cycle
			check_value("busy", 128'(busy), 128'(1));
		end
		if (!seen) begin
			abort_run($sformatf("no fetch_valid for pc %h", a));
		end else begin
			check_value("mem_req count", 128'(req_count - base_reqs), 128'(exp_fill_q.size()));
			for (int i = 0; i < exp_fill_q.size(); i++)
				if (i < fill_log.size())
					check_value("mem_addr", 128'(fill_log[i]), 128'(exp_fill_q[i]));
			// Hit shows valid two cycles after the sampling edge
			if (exp_fill_q.size() == 0)
				check_value("hit latency", 128'(cycles), 128'(3));
			// Busy drops right after the valid cycle
			@(negedge rclk);
			check_value("busy", 128'(busy), 128'(0));
		end
	endtask

	task automatic expect_quiet(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge rclk);
			if (fetch_valid) begin
				others++;
				$display("Extra fetch_valid at %0t after an ignored request", $time);
			end
		end
	endtask

	task automatic flush_cache();
		wait_idle();
		invalidate = 1'b1;
		@(negedge rclk);
		invalidate = 1'b0;
		for (int i = 0; i < 128; i++)
			shadow_valid[i] = 1'b0;
	endtask

	// ====================
	// Memory model and compare process
	// ====================

	initial begin : memory_model
		logic [31:0] addr;
		logic [31:0] lat;
		forever begin
			@(negedge rclk);
			if (arst_n === 1'b1 && mem_req) begin
				addr = mem_addr;
				req_count++;
				fill_log.push_back(addr);
				// Latency of 1 to 8 cycles
				draw_bits(3, lat);
				repeat (lat + 1) @(negedge rclk);
				mem_ack = 1'b1;
				mem_data = mem_line(addr);
				mem_err = err_region(addr);
				@(negedge rclk);
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : compare
		logic [31:0]                   a;
		logic [icache_pkg::BUNDLE_W:0] exp;
		forever begin
			@(negedge rclk);
			if (fetch_valid === 1'b1) begin
				if (exp_pc_q.size() == 0) begin
					others++;
					$display("fetch_valid at %0t with no fetch outstanding", $time);
				end else begin
					a = exp_pc_q.pop_front();
					exp = expected_fetch(a);
					check_value("fetch_data", fetch_data, exp[icache_pkg::BUNDLE_W-1:0]);
					check_value("fetch_err", 128'(fetch_err), 128'(exp[icache_pkg::BUNDLE_W]));
				end
			end
		end
	end

	// ====================
	// Stimulus
	// ====================

	initial begin : stimulus
		logic [31:0] rnd;
		arst_n = 1'b0;
		fetch_req = 1'b0;
		pc = '0;
		invalidate = 1'b0;
		mem_ack = 1'b0;
		mem_data = '0;
		mem_err = 1'b0;
		for (int i = 0; i < 128; i++)
			shadow_valid[i] = 1'b0;
		repeat (16) @(negedge rclk);
		arst_n = 1'b1;
		@(negedge rclk);
		// Cold miss on one line, then the same pc hits
		fetch_once(32'h0000_0104, 1'b0, '0);
		fetch_once(32'h0000_0104, 1'b0, '0);
		// Straddling bundles, two fills each
		fetch_once(32'h0000_0538, 1'b0, '0);
		fetch_once(32'h0000_0538, 1'b0, '0);
		fetch_once(32'h0000_0610, 1'b0, '0);
		// Error lines, on miss and on hit, and a clean neighbour
		fetch_once(32'h0000_F204, 1'b0, '0);
		fetch_once(32'h0000_F204, 1'b0, '0);
		fetch_once(32'h0000_EFF8, 1'b0, '0);
		fetch_once(32'h0000_E104, 1'b0, '0);
		// After a flush the first pc has to refill
		flush_cache();
		fetch_once(32'h0000_0104, 1'b0, '0);
		// Second request during busy is dropped
		fetch_once(32'h0000_0704, 1'b1, 32'h0000_0900);
		expect_quiet(20);
		// 8 KB window with its upper half in the error region
		for (int n = 0; n < 300; n++) begin
			draw_bits(13, rnd);
			fetch_once(32'h0000_E000 + rnd, 1'b0, '0);
		end
		wait_idle();
		repeat (2) @(negedge rclk);
		check_value("pending fetches", 128'(exp_pc_q.size()), '0);
		$display("Checks %0d, mismatches %0d, other failures %0d", checks, mismatches, others);
		if (mismatches == 0 && others == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- test/icache_checker.sv
// ====================
// Concurrent protocol assertions for the cache ports
// ====================

`timescale 1ns/1ps

module icache_checker (
	input logic rclk,
	input logic arst_n,
	input logic busy,
	input logic fetch_valid,
	input logic mem_req,
	input logic invalidate
);

	// Bundle valid is a one-cycle pulse
	a_valid_pulse: assert property (@(posedge rclk) disable iff (!arst_n)
		fetch_valid |=> !fetch_valid)
		else $error("fetch_valid held high for two cycles");

	// Memory traffic only inside a request
	a_req_busy: assert property (@(posedge rclk) disable iff (!arst_n)
		mem_req |-> busy)
		else $error("mem_req while busy is low");

	// Flush only when the cache is idle
	a_inv_idle: assert property (@(posedge rclk) disable iff (!arst_n)
		invalidate |-> !busy)
		else $error("invalidate while busy is high");

	// Valid always closes a busy window
	a_valid_after_busy: assert property (@(posedge rclk) disable iff (!arst_n)
		fetch_valid |-> $past(busy))
		else $error("fetch_valid without busy in the previous cycle");

endmodule

// Watches the core and memory ports of the cache
bind icache_top icache_checker u_checker (
	.rclk(rclk), .arst_n(arst_n), .busy(busy), .fetch_valid(fetch_valid),
	.mem_req(mem_req), .invalidate(invalidate)
);

//--- logic/icache_top.sv
// ====================
// Instruction fetch cache top level
// ====================

`timescale 1ns/1ps

module icache_top #(
	parameter int ADDR_W = 32
) (
	input  logic                            rclk,
	input  logic                            arst_n,
	// Core side
	input  logic                            fetch_req,
	input  logic [ADDR_W-1:0]               pc,
	input  logic                            invalidate,
	output logic                            busy,
	output logic                            fetch_valid,
	output logic [icache_pkg::BUNDLE_W-1:0] fetch_data,
	output logic                            fetch_err,
	// Memory side
	output logic                            mem_req,
	output logic [ADDR_W-1:0]               mem_addr,
	input  logic                            mem_ack,
	input  logic [icache_pkg::LINE_W-1:0]   mem_data,
	input  logic                            mem_err
);

	// Lookup path
	logic                          lookup_ce;
	logic [ADDR_W-1:0]             lookup_pc;
	logic [ADDR_W-1:0]             rpc;
	logic                          hit0;
	logic                          hit1;
	logic                          line_err;
	logic                          done;
	// Refill path
	logic                          fill_we;
	logic [ADDR_W-1:0]             fill_addr;
	logic [icache_pkg::LINE_W-1:0] fill_data;
	logic                          fill_err;
	// Line reads
	logic [icache_pkg::LINE_W-1:0] line0;
	logic [icache_pkg::LINE_W-1:0] line1;

	icache_tag_mem #(.ADDR_W(ADDR_W)) u_tag_mem (
		.rclk(rclk), .arst_n(arst_n), .lookup_ce(lookup_ce), .lookup_pc(lookup_pc),
		.fill_we(fill_we), .fill_addr(fill_addr), .fill_err(fill_err),
		.invalidate(invalidate), .rpc(rpc), .hit0(hit0), .hit1(hit1),
		.line_err(line_err)
	);

	icache_data_mem #(.ADDR_W(ADDR_W)) u_data_mem (
		.rclk(rclk), .lookup_ce(lookup_ce), .lookup_pc(lookup_pc),
		.fill_we(fill_we), .fill_addr(fill_addr), .fill_data(fill_data),
		.line0(line0), .line1(line1)
	);

	icache_fill_ctrl #(.ADDR_W(ADDR_W)) u_fill_ctrl (
		.rclk(rclk), .arst_n(arst_n), .fetch_req(fetch_req), .pc(pc),
		.hit0(hit0), .hit1(hit1), .mem_ack(mem_ack), .mem_data(mem_data),
		.mem_err(mem_err), .busy(busy), .lookup_ce(lookup_ce),
		.lookup_pc(lookup_pc), .done(done), .mem_req(mem_req), .mem_addr(mem_addr),
		.fill_we(fill_we), .fill_addr(fill_addr), .fill_data(fill_data),
		.fill_err(fill_err)
	);

	icache_bundle_align #(.ADDR_W(ADDR_W)) u_bundle_align (
		.rclk(rclk), .arst_n(arst_n), .done(done), .rpc(rpc),
		.line0(line0), .line1(line1), .line_err(line_err),
		.fetch_valid(fetch_valid), .fetch_data(fetch_data), .fetch_err(fetch_err)
	);

endmodule

//--- logic/icache_bundle_align.sv
// ====================
// Bundle extraction from two cache lines
// Registered fetch outputs
// ====================

`timescale 1ns/1ps

module icache_bundle_align #(
	parameter int ADDR_W = 32
) (
	input  logic                            rclk,
	input  logic                            arst_n,
	input  logic                            done,
	input  logic [ADDR_W-1:0]               rpc,
	input  logic [icache_pkg::LINE_W-1:0]   line0,
	input  logic [icache_pkg::LINE_W-1:0]   line1,
	input  logic                            line_err,
	output logic                            fetch_valid,
	output logic [icache_pkg::BUNDLE_W-1:0] fetch_data,
	output logic                            fetch_err
);

	logic [2*icache_pkg::LINE_W-1:0]   pair;
	logic [icache_pkg::OFFSET_W-1:0]   offset;
	logic [icache_pkg::BUNDLE_W-1:0]   bundle;

	// Line of pc in the low half, byte 0 in bits 7:0
	assign pair = {line1, line0};

	// Byte offset within the first line
	assign offset = rpc[icache_pkg::OFFSET_W-1:0];

	// Offsets past 16 spill into line1
	assign bundle = pair[{offset, 3'b000} +: icache_pkg::BUNDLE_W];

	// ====================
	// Output registers
	// ====================

	// Data and error flag are payload, loaded on done only
	always_ff @(posedge rclk) begin
		if (done) begin
			fetch_data <= bundle;
			fetch_err  <= line_err;
		end
	end

	// Single-cycle valid pulse
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n)
			fetch_valid <= 1'b0;
		else
			fetch_valid <= done;
	end

endmodule

//--- logic/icache_fill_ctrl.sv
// ====================
// Fetch request capture and miss refill FSM
// Drives lookups, memory requests and line writes
// ====================

`timescale 1ns/1ps

module icache_fill_ctrl #(
	parameter int ADDR_W = 32
) (
	input  logic                          rclk,
	input  logic                          arst_n,
	input  logic                          fetch_req,
	input  logic [ADDR_W-1:0]             pc,
	input  logic                          hit0,
	input  logic                          hit1,
	input  logic                          mem_ack,
	input  logic [icache_pkg::LINE_W-1:0] mem_data,
	input  logic                          mem_err,
	output logic                          busy,
	output logic                          lookup_ce,
	output logic [ADDR_W-1:0]             lookup_pc,
	output logic                          done,
	output logic                          mem_req,
	output logic [ADDR_W-1:0]             mem_addr,
	output logic                          fill_we,
	output logic [ADDR_W-1:0]             fill_addr,
	output logic [icache_pkg::LINE_W-1:0] fill_data,
	output logic                          fill_err
);

	icache_pkg::fill_state_e state;

	logic [ADDR_W-1:0] pc_q;
	logic [ADDR_W-1:0] pc_p16;
	logic [ADDR_W-1:0] miss_line;
	logic              accept;
	logic              done_q;
	logic              refill;

	// ====================
	// Request side
	// ====================

	// Requests during busy are dropped
	assign accept = fetch_req & ~busy;

	// Busy covers the FSM, the done cycle and the fetch_valid cycle
	assign busy = (state != icache_pkg::FS_IDLE) | done | done_q;

	// Memory answered, line gets written and lookup restarts
	assign refill = (state == icache_pkg::FS_WAIT) & mem_ack;

	// New pc on accept, captured pc on relookup
	assign lookup_ce = accept | refill;
	assign lookup_pc = accept ? pc : pc_q;

	// Line of pc goes first, then line of pc+16
	assign pc_p16    = pc_q + ADDR_W'(icache_pkg::BUNDLE_BYTES);
	assign miss_line = hit0 ? pc_p16 : pc_q;

	// ====================
	// Memory and fill side
	// ====================

	// One-cycle strobe while in FS_FILL
	assign mem_req = (state == icache_pkg::FS_FILL);

	// Memory data goes straight into the arrays
	assign fill_we   = refill;
	assign fill_addr = mem_addr;
	assign fill_data = mem_data;
	assign fill_err  = mem_err;

	// Captured pc and address of the missing line
	always_ff @(posedge rclk) begin
		if (accept)
			pc_q <= pc;
		if (state == icache_pkg::FS_LOOKUP && !(hit0 && hit1))
			mem_addr <= {miss_line[ADDR_W-1:icache_pkg::OFFSET_W],
				{icache_pkg::OFFSET_W{1'b0}}};
	end

	// FSM, done pulse and its delayed copy
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= icache_pkg::FS_IDLE;
			done   <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done   <= 1'b0;
			done_q <= done;
			case (state)
				icache_pkg::FS_IDLE: begin
					if (accept)
						state <= icache_pkg::FS_LOOKUP;
				end
				icache_pkg::FS_LOOKUP: begin
					// Both lines present, hand over to the aligner
					if (hit0 && hit1) begin
						done  <= 1'b1;
						state <= icache_pkg::FS_IDLE;
					end else begin
						state <= icache_pkg::FS_FILL;
					end
				end
				icache_pkg::FS_FILL: begin
					state <= icache_pkg::FS_WAIT;
				end
				icache_pkg::FS_WAIT: begin
					// Memory latency is the only stall
					if (mem_ack)
						state <= icache_pkg::FS_LOOKUP;
				end
				default: begin
					state <= icache_pkg::FS_IDLE;
				end
			endcase
		end
	end

endmodule

//--- logic/icache_data_mem.sv
// ====================
// Line data array of the instruction cache
// Dual registered-index read, whole-line write
// ====================

`timescale 1ns/1ps

module icache_data_mem #(
	parameter int ADDR_W = 32
) (
	input  logic                          rclk,
	input  logic                          lookup_ce,
	input  logic [ADDR_W-1:0]             lookup_pc,
	input  logic                          fill_we,
	input  logic [ADDR_W-1:0]             fill_addr,
	input  logic [icache_pkg::LINE_W-1:0] fill_data,
	output logic [icache_pkg::LINE_W-1:0] line0,
	output logic [icache_pkg::LINE_W-1:0] line1
);

	localparam int IDX_LSB = icache_pkg::OFFSET_W;
	localparam int IDX_MSB = icache_pkg::OFFSET_W + icache_pkg::INDEX_W - 1;
	localparam int LINES   = 2 ** icache_pkg::INDEX_W;

	logic [icache_pkg::LINE_W-1:0]   line_arr [LINES];
	logic [ADDR_W-1:0]               pc_p16;
	logic [icache_pkg::INDEX_W-1:0]  ridx0;
	logic [icache_pkg::INDEX_W-1:0]  ridx1;

	// Second line follows the bundle end
	assign pc_p16 = lookup_pc + ADDR_W'(icache_pkg::BUNDLE_BYTES);

	// ====================
	// Storage
	// ====================

	// Whole line arrives in one beat from the fill path
	always_ff @(posedge rclk) begin
		if (fill_we)
			line_arr[fill_addr[IDX_MSB:IDX_LSB]] <= fill_data;
	end

	// Read indices load together with the tag lookup
	always_ff @(posedge rclk) begin
		if (lookup_ce) begin
			ridx0 <= lookup_pc[IDX_MSB:IDX_LSB];
			ridx1 <= pc_p16[IDX_MSB:IDX_LSB];
		end
	end

	// Asynchronous read from the held indices
	// a refill on the lookup edge shows up here too
	assign line0 = line_arr[ridx0];
	assign line1 = line_arr[ridx1];

endmodule

//--- logic/icache_tag_mem.sv
// ====================
// Tag, valid and error arrays of the instruction cache
// Registered lookup of the lines of pc and pc+16
// ====================

`timescale 1ns/1ps

module icache_tag_mem #(
	parameter int ADDR_W = 32
) (
	input  logic              rclk,
	input  logic              arst_n,
	input  logic              lookup_ce,
	input  logic [ADDR_W-1:0] lookup_pc,
	input  logic              fill_we,
	input  logic [ADDR_W-1:0] fill_addr,
	input  logic              fill_err,
	input  logic              invalidate,
	output logic [ADDR_W-1:0] rpc,
	output logic              hit0,
	output logic              hit1,
	output logic              line_err
);

	// Tag sits above index and offset
	localparam int TAG_LSB = icache_pkg::OFFSET_W + icache_pkg::INDEX_W;
	localparam int LINES   = 2 ** icache_pkg::INDEX_W;

	logic [ADDR_W-1:TAG_LSB]         tag_arr [LINES];
	logic [LINES-1:0]                valid_arr;
	logic [LINES-1:0]                err_arr;
	logic [ADDR_W-1:0]               rpc_p16;
	logic [icache_pkg::INDEX_W-1:0]  widx;
	logic [icache_pkg::INDEX_W-1:0]  ridx0;
	logic [icache_pkg::INDEX_W-1:0]  ridx1;

	// Index fields of the write and both lookups
	assign widx  = fill_addr[TAG_LSB-1:icache_pkg::OFFSET_W];
	assign ridx0 = rpc[TAG_LSB-1:icache_pkg::OFFSET_W];
	assign ridx1 = rpc_p16[TAG_LSB-1:icache_pkg::OFFSET_W];

	// ====================
	// Write side
	// ====================

	// Tag array is plain storage
	always_ff @(posedge rclk) begin
		if (fill_we)
			tag_arr[widx] <= fill_addr[ADDR_W-1:TAG_LSB];
	end

	// Valid and error bits, flash cleared by invalidate
	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			valid_arr <= '0;
			err_arr   <= '0;
		end else if (invalidate) begin
			valid_arr <= '0;
			err_arr   <= '0;
		end else if (fill_we) begin
			valid_arr[widx] <= 1'b1;
			err_arr[widx]   <= fill_err;
		end
	end

	// ====================
	// Lookup side
	// ====================

	// Capture pc and the address of the following half bundle
	always_ff @(posedge rclk) begin
		if (lookup_ce) begin
			rpc     <= lookup_pc;
			rpc_p16 <= lookup_pc + ADDR_W'(icache_pkg::BUNDLE_BYTES);
		end
	end

	// Compare against registered addresses, so a fill on the
	// same edge as the lookup is already visible
	assign hit0 = valid_arr[ridx0] && (tag_arr[ridx0] == rpc[ADDR_W-1:TAG_LSB]);
	assign hit1 = valid_arr[ridx1] && (tag_arr[ridx1] == rpc_p16[ADDR_W-1:TAG_LSB]);

	// Either line flagged bad taints the bundle
	assign line_err = err_arr[ridx0] | err_arr[ridx1];

endmodule

//--- logic/icache_pkg.sv
// ====================
// Instruction cache geometry constants
// Fill controller state encoding
// ====================

package icache_pkg;

	// ====================
	// Line geometry
	// ====================

	// Bytes held by one cache line
	localparam int LINE_BYTES = 32;

	// One line as a flat bit vector
	localparam int LINE_W = LINE_BYTES * 8;

	// 128 lines, direct mapped
	localparam int INDEX_W = 7;

	// Byte position inside a line
	localparam int OFFSET_W = $clog2(LINE_BYTES);

	// ====================
	// Fetch bundle
	// ====================

	// Core fetches 16 bytes per request
	localparam int BUNDLE_BYTES = 16;
	localparam int BUNDLE_W = BUNDLE_BYTES * 8;

	// Fill controller FSM
	typedef enum logic [1:0] {
		FS_IDLE   = 2'd0,   // waiting for a fetch
		FS_LOOKUP = 2'd1,   // tag compare of both lines
		FS_FILL   = 2'd2,   // issue memory request
		FS_WAIT   = 2'd3    // wait for memory ack
	} fill_state_e;

endpackage
